/* tb.f */
hdl/rs_params_pkg.sv
hdl/rs_types_pkg.sv
hdl/operand_snoop.sv
hdl/rs_entry.sv
hdl/issue_select.sv
hdl/reservation_station.sv
dv/rs_checker.sv
dv/tb_reservation_station.sv

/* dv/tb_reservation_station.sv */
`timescale 1ns/1ps

// Random dispatch and CDB traffic against the reservation station
module tb_reservation_station
    import rs_params_pkg::*, rs_types_pkg::*;
();

    localparam int clk_period      = 40;
    localparam int reset_cycles    = 4;
    localparam int num_cycles      = 2000;
    localparam int drain_cycles    = 8;
    localparam int watchdog_cycles = num_cycles + 500;

    logic                  clk;
    logic                  reset;
    logic                  dispatch_valid;
    logic                  dispatch_ready;
    alu_op_t               dispatch_op;
    logic [pc_width-1:0]   dispatch_pc;
    logic [preg_width-1:0] dispatch_rd;
    tag_t                  a_tag;
    logic [data_width-1:0] a_data;
    tag_t                  b_tag;
    logic [data_width-1:0] b_data;
    logic                  cdb_valid_0;
    logic [data_width-1:0] cdb_data_0;
    logic                  cdb_valid_1;
    logic [data_width-1:0] cdb_data_1;
    logic                  cdb_valid_2;
    logic [data_width-1:0] cdb_data_2;
    logic                  cdb_valid_load;
    logic [preg_width-1:0] cdb_dest_load;
    logic [data_width-1:0] cdb_data_load;
    logic                  issue_ready;
    logic                  issue_valid;
    alu_op_t               issue_op;
    logic [pc_width-1:0]   issue_pc;
    logic [preg_width-1:0] issue_rd;
    logic [data_width-1:0] issue_a;
    logic [data_width-1:0] issue_b;
    logic                  run_done;
    int                    error_count;
    int                    issue_count;
    logic                  end_checked;
    integer                seed;
    int                    cycle;

    reservation_station dut0 (.*);

    rs_checker chk0 (.*);

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    function automatic tag_t pick_tag(input logic [31:0] r);
        case (r % 5)
            0: return tag_alu0;
            1: return tag_alu1;
            2: return tag_alu2;
            3: return tag_load;
            default: return tag_ready;
        endcase
    endfunction

    // Load operands await registers 0 to 3 so the load channel hits often
    function automatic logic [data_width-1:0] operand_word(input tag_t tag,
                                                           input logic [31:0] r);
        logic [data_width-1:0] word;
        word = r;
        if (tag == tag_load)
            word[preg_width-1:0] = preg_width'(r[1:0]);
        return word;
    endfunction

    task automatic drive_idle();
        dispatch_valid = 1'b0;
        dispatch_op    = op_add;
        dispatch_pc    = '0;
        dispatch_rd    = '0;
        a_tag          = tag_ready;
        a_data         = '0;
        b_tag          = tag_ready;
        b_data         = '0;
        cdb_valid_0    = 1'b0;
        cdb_data_0     = '0;
        cdb_valid_1    = 1'b0;
        cdb_data_1     = '0;
        cdb_valid_2    = 1'b0;
        cdb_data_2     = '0;
        cdb_valid_load = 1'b0;
        cdb_dest_load  = '0;
        cdb_data_load  = '0;
        issue_ready    = 1'b1;
    endtask

    task automatic drive_random();
        dispatch_valid = ($unsigned($random(seed)) % 4) != 0;
        dispatch_op    = alu_op_t'(4'($unsigned($random(seed)) % 8));
        dispatch_pc    = $random(seed);
        dispatch_rd    = preg_width'($unsigned($random(seed)));
        a_tag          = pick_tag($random(seed));
        a_data         = operand_word(a_tag, $random(seed));
        b_tag          = pick_tag($random(seed));
        b_data         = operand_word(b_tag, $random(seed));
        cdb_valid_0    = ($unsigned($random(seed)) % 3) == 0;
        cdb_data_0     = $random(seed);
        cdb_valid_1    = ($unsigned($random(seed)) % 3) == 0;
        cdb_data_1     = $random(seed);
        cdb_valid_2    = ($unsigned($random(seed)) % 3) == 0;
        cdb_data_2     = $random(seed);
        cdb_valid_load = ($unsigned($random(seed)) % 3) == 0;
        cdb_dest_load  = preg_width'($unsigned($random(seed)) % 4);
        cdb_data_load  = $random(seed);
        // Functional unit stalls about a quarter of the time
        issue_ready    = ($unsigned($random(seed)) % 4) != 0;
    endtask

    // Every channel broadcasts so a held instruction can finish
    task automatic drive_drain(input int k);
        drive_idle();
        cdb_valid_0    = 1'b1;
        cdb_data_0     = $random(seed);
        cdb_valid_1    = 1'b1;
        cdb_data_1     = $random(seed);
        cdb_valid_2    = 1'b1;
        cdb_data_2     = $random(seed);
        cdb_valid_load = 1'b1;
        cdb_dest_load  = preg_width'(k % 4);
        cdb_data_load  = $random(seed);
    endtask

    // ====================
    // Main sequence
    // ====================

    initial begin
        seed     = 32'hee98;
        reset    = 1'b0;
        run_done = 1'b0;
        drive_idle();
        repeat (reset_cycles) @(posedge clk);
        #2;
        reset = 1'b1;
        for (cycle = 0; cycle < num_cycles; cycle++) begin
            drive_random();
            @(posedge clk);
            #2;
        end
        for (cycle = 0; cycle < drain_cycles; cycle++) begin
            drive_drain(cycle);
            @(posedge clk);
            #2;
        end
        drive_idle();
        run_done = 1'b1;
        wait (end_checked);
        $display("Closing report: %0d issues checked, %0d errors", issue_count, error_count);
        if (error_count == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("Watchdog expired after %0d cycles, the run hung", watchdog_cycles);
        $display("Test failed");
        $finish;
    end

endmodule

/* dv/rs_checker.sv */
`timescale 1ns/1ps

// Reference model of the station that compares every issued instruction
module rs_checker
    import rs_params_pkg::*, rs_types_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  dispatch_valid,
    input  logic                  dispatch_ready,
    input  alu_op_t               dispatch_op,
    input  logic [pc_width-1:0]   dispatch_pc,
    input  logic [preg_width-1:0] dispatch_rd,
    input  tag_t                  a_tag,
    input  logic [data_width-1:0] a_data,
    input  tag_t                  b_tag,
    input  logic [data_width-1:0] b_data,
    input  logic                  cdb_valid_0,
    input  logic [data_width-1:0] cdb_data_0,
    input  logic                  cdb_valid_1,
    input  logic [data_width-1:0] cdb_data_1,
    input  logic                  cdb_valid_2,
    input  logic [data_width-1:0] cdb_data_2,
    input  logic                  cdb_valid_load,
    input  logic [preg_width-1:0] cdb_dest_load,
    input  logic [data_width-1:0] cdb_data_load,
    input  logic                  issue_ready,
    input  logic                  issue_valid,
    input  alu_op_t               issue_op,
    input  logic [pc_width-1:0]   issue_pc,
    input  logic [preg_width-1:0] issue_rd,
    input  logic [data_width-1:0] issue_a,
    input  logic [data_width-1:0] issue_b,
    input  logic                  run_done,
    output int                    error_count,
    output int                    issue_count,
    output logic                  end_checked
);

    // Model of the single entry
    logic                  m_enable;
    logic                  m_occupied;
    alu_op_t               m_op;
    logic [pc_width-1:0]   m_pc;
    logic [preg_width-1:0] m_rd;
    tag_t                  m_a_tag;
    tag_t                  m_b_tag;
    logic [data_width-1:0] m_a_data;
    logic [data_width-1:0] m_b_data;
    logic                  issue_due;
    logic                  exp_ready;
    logic                  accept;
    int                    accept_count;

    // Resolved flag on top, operand value below
    logic [data_width:0]   held_a;
    logic [data_width:0]   held_b;
    logic [data_width:0]   new_a;
    logic [data_width:0]   new_b;

    // Expected issues in dispatch order
    alu_op_t               exp_op_q[$];
    logic [pc_width-1:0]   exp_pc_q[$];
    logic [preg_width-1:0] exp_rd_q[$];
    logic [data_width-1:0] exp_a_q[$];
    logic [data_width-1:0] exp_b_q[$];

    initial begin
        error_count  = 0;
        issue_count  = 0;
        accept_count = 0;
        end_checked  = 1'b0;
        m_enable     = 1'b0;
        m_occupied   = 1'b0;
        issue_due    = 1'b0;
    end

    // Held data first, then the matching CDB channel
    function automatic logic [data_width:0] resolve_operand(
        input tag_t tag, input logic [data_width-1:0] data);
        logic [data_width:0] result;
        result = {1'b0, data};
        if (tag == tag_ready)
            result = {1'b1, data};
        else if (tag == tag_alu0 && cdb_valid_0)
            result = {1'b1, cdb_data_0};
        else if (tag == tag_alu1 && cdb_valid_1)
            result = {1'b1, cdb_data_1};
        else if (tag == tag_alu2 && cdb_valid_2)
            result = {1'b1, cdb_data_2};
        else if (tag == tag_load && cdb_valid_load && data[preg_width-1:0] == cdb_dest_load)
            result = {1'b1, cdb_data_load};
        return result;
    endfunction

    task automatic compare_field(input string name, input logic [data_width-1:0] expected,
                                 input logic [data_width-1:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic push_expected(input alu_op_t op, input logic [pc_width-1:0] pc,
                                 input logic [preg_width-1:0] rd,
                                 input logic [data_width-1:0] a,
                                 input logic [data_width-1:0] b);
        exp_op_q.push_back(op);
        exp_pc_q.push_back(pc);
        exp_rd_q.push_back(rd);
        exp_a_q.push_back(a);
        exp_b_q.push_back(b);
    endtask

    task automatic check_issue();
        issue_count++;
        if (exp_op_q.size() == 0) begin
            error_count++;
            $display("Issue at pc %h with no instruction outstanding in the model", issue_pc);
        end else begin
            compare_field("issue_op", exp_op_q.pop_front(), issue_op);
            compare_field("issue_pc", exp_pc_q.pop_front(), issue_pc);
            compare_field("issue_rd", exp_rd_q.pop_front(), issue_rd);
            compare_field("issue_a", exp_a_q.pop_front(), issue_a);
            compare_field("issue_b", exp_b_q.pop_front(), issue_b);
        end
    endtask

    // ====================
    // Cycle model
    // ====================

    // Sampled mid-cycle where inputs and outputs are settled
    always @(negedge clk) begin
        if (!reset) begin
            compare_field("reset_issue_valid", 1'b0, issue_valid);
            compare_field("reset_dispatch_ready", 1'b0, dispatch_ready);
            m_enable   = 1'b0;
            m_occupied = 1'b0;
            issue_due  = 1'b0;
        end else begin
            compare_field("issue_valid", issue_due, issue_valid);
            // Every issue is matched against the oldest outstanding dispatch
            if (issue_valid)
                check_issue();
            exp_ready = m_enable && !m_occupied && issue_ready;
            compare_field("dispatch_ready", exp_ready, dispatch_ready);
            accept = dispatch_valid && exp_ready;
            held_a = resolve_operand(m_a_tag, m_a_data);
            held_b = resolve_operand(m_b_tag, m_b_data);
            new_a  = resolve_operand(a_tag, a_data);
            new_b  = resolve_operand(b_tag, b_data);
            issue_due = 1'b0;
            if (m_occupied && held_a[data_width] && held_b[data_width] && issue_ready) begin
                push_expected(m_op, m_pc, m_rd, held_a[data_width-1:0], held_b[data_width-1:0]);
                m_occupied = 1'b0;
                issue_due  = 1'b1;
            end else if (accept && new_a[data_width] && new_b[data_width]) begin
                push_expected(dispatch_op, dispatch_pc, dispatch_rd,
                              new_a[data_width-1:0], new_b[data_width-1:0]);
                issue_due = 1'b1;
            end else if (accept) begin
                m_occupied = 1'b1;
                m_op       = dispatch_op;
                m_pc       = dispatch_pc;
                m_rd       = dispatch_rd;
                m_a_tag    = new_a[data_width] ? tag_ready : a_tag;
                m_b_tag    = new_b[data_width] ? tag_ready : b_tag;
                m_a_data   = new_a[data_width-1:0];
                m_b_data   = new_b[data_width-1:0];
            end else if (m_occupied) begin
                // Operands keep snooping under back-pressure
                if (held_a[data_width]) begin
                    m_a_tag  = tag_ready;
                    m_a_data = held_a[data_width-1:0];
                end
                if (held_b[data_width]) begin
                    m_b_tag  = tag_ready;
                    m_b_data = held_b[data_width-1:0];
                end
            end
            if (accept)
                accept_count++;
            m_enable = 1'b1;
            if (run_done && !end_checked) begin
                if (exp_op_q.size() != 0 || m_occupied || issue_due) begin
                    error_count++;
                    $display("Instructions still outstanding at the end of the run");
                end
                if (accept_count != issue_count) begin
                    error_count++;
                    $display("%0d dispatches accepted but %0d issued", accept_count, issue_count);
                end
                end_checked = 1'b1;
            end
        end
    end

endmodule

/* hdl/reservation_station.sv */
`timescale 1ns/1ps

// Single-entry reservation station for one ALU
module reservation_station
    import rs_params_pkg::*, rs_types_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,

    // Dispatch from decode
    input  logic                  dispatch_valid,
    output logic                  dispatch_ready,
    input  alu_op_t               dispatch_op,
    input  logic [pc_width-1:0]   dispatch_pc,
    input  logic [preg_width-1:0] dispatch_rd,
    input  tag_t                  a_tag,
    input  logic [data_width-1:0] a_data,
    input  tag_t                  b_tag,
    input  logic [data_width-1:0] b_data,

    // CDB
    input  logic                  cdb_valid_0,
    input  logic [data_width-1:0] cdb_data_0,
    input  logic                  cdb_valid_1,
    input  logic [data_width-1:0] cdb_data_1,
    input  logic                  cdb_valid_2,
    input  logic [data_width-1:0] cdb_data_2,
    input  logic                  cdb_valid_load,
    input  logic [preg_width-1:0] cdb_dest_load,
    input  logic [data_width-1:0] cdb_data_load,

    // Issue to the functional unit
    input  logic                  issue_ready,
    output logic                  issue_valid,
    output alu_op_t               issue_op,
    output logic [pc_width-1:0]   issue_pc,
    output logic [preg_width-1:0] issue_rd,
    output logic [data_width-1:0] issue_a,
    output logic [data_width-1:0] issue_b
);

    logic                  capture;
    logic                  release_entry;
    logic                  occupied;
    alu_op_t               held_op;
    logic [pc_width-1:0]   held_pc;
    logic [preg_width-1:0] held_rd;
    logic                  a_resolved;
    logic [data_width-1:0] a_value;
    logic                  b_resolved;
    logic [data_width-1:0] b_value;
    logic                  new_a_resolved;
    logic [data_width-1:0] new_a_value;
    logic                  new_b_resolved;
    logic [data_width-1:0] new_b_value;

    rs_entry entry0 (
        .clk(clk), .reset(reset), .capture(capture), .release_entry(release_entry),
        .dispatch_op(dispatch_op), .dispatch_pc(dispatch_pc), .dispatch_rd(dispatch_rd),
        .a_tag(a_tag), .a_data(a_data), .b_tag(b_tag), .b_data(b_data),
        .cdb_valid_0(cdb_valid_0), .cdb_data_0(cdb_data_0),
        .cdb_valid_1(cdb_valid_1), .cdb_data_1(cdb_data_1),
        .cdb_valid_2(cdb_valid_2), .cdb_data_2(cdb_data_2),
        .cdb_valid_load(cdb_valid_load), .cdb_dest_load(cdb_dest_load),
        .cdb_data_load(cdb_data_load),
        .occupied(occupied), .held_op(held_op), .held_pc(held_pc), .held_rd(held_rd),
        .a_resolved(a_resolved), .a_value(a_value),
        .b_resolved(b_resolved), .b_value(b_value),
        .new_a_resolved(new_a_resolved), .new_a_value(new_a_value),
        .new_b_resolved(new_b_resolved), .new_b_value(new_b_value)
    );

    issue_select select0 (
        .clk(clk), .reset(reset), .dispatch_valid(dispatch_valid),
        .issue_ready(issue_ready), .occupied(occupied),
        .held_op(held_op), .held_pc(held_pc), .held_rd(held_rd),
        .a_resolved(a_resolved), .a_value(a_value),
        .b_resolved(b_resolved), .b_value(b_value),
        .new_a_resolved(new_a_resolved), .new_a_value(new_a_value),
        .new_b_resolved(new_b_resolved), .new_b_value(new_b_value),
        .dispatch_op(dispatch_op), .dispatch_pc(dispatch_pc), .dispatch_rd(dispatch_rd),
        .dispatch_ready(dispatch_ready), .capture(capture), .release_entry(release_entry),
        .issue_valid(issue_valid), .issue_op(issue_op), .issue_pc(issue_pc),
        .issue_rd(issue_rd), .issue_a(issue_a), .issue_b(issue_b)
    );

endmodule

/* hdl/issue_select.sv */
`timescale 1ns/1ps

// Issue decision and the registered port to the functional unit
module issue_select
    import rs_params_pkg::*, rs_types_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  dispatch_valid,
    input  logic                  issue_ready,
    input  logic                  occupied,
    input  alu_op_t               held_op,
    input  logic [pc_width-1:0]   held_pc,
    input  logic [preg_width-1:0] held_rd,
    input  logic                  a_resolved,
    input  logic [data_width-1:0] a_value,
    input  logic                  b_resolved,
    input  logic [data_width-1:0] b_value,
    input  logic                  new_a_resolved,
    input  logic [data_width-1:0] new_a_value,
    input  logic                  new_b_resolved,
    input  logic [data_width-1:0] new_b_value,
    input  alu_op_t               dispatch_op,
    input  logic [pc_width-1:0]   dispatch_pc,
    input  logic [preg_width-1:0] dispatch_rd,
    output logic                  dispatch_ready,
    output logic                  capture,
    output logic                  release_entry,
    output logic                  issue_valid,
    output alu_op_t               issue_op,
    output logic [pc_width-1:0]   issue_pc,
    output logic [preg_width-1:0] issue_rd,
    output logic [data_width-1:0] issue_a,
    output logic [data_width-1:0] issue_b
);

    // What happens to the pipeline in the current cycle
    typedef enum logic [1:0] {
        sel_idle,
        sel_capture,
        sel_direct,
        sel_held
    } sel_t;

    logic enable;
    logic accept;
    logic held_issue;
    sel_t sel;

    // Keeps the station closed for the first cycle out of reset
    always_ff @(posedge clk or negedge reset) begin
        if (!reset)
            enable <= 1'b0;
        else
            enable <= 1'b1;
    end

    assign dispatch_ready = enable && !occupied && issue_ready;
    assign accept         = dispatch_valid && dispatch_ready;
    assign held_issue     = occupied && a_resolved && b_resolved && issue_ready;

    // ====================
    // Issue decision
    // ====================

    always_comb begin
        if (held_issue)
            sel = sel_held;
        else if (accept && new_a_resolved && new_b_resolved)
            sel = sel_direct;
        else if (accept)
            sel = sel_capture;
        else
            sel = sel_idle;
    end

    assign capture       = (sel == sel_capture);
    assign release_entry = (sel == sel_held);

    // ====================
    // Issue register
    // ====================

    always_ff @(posedge clk or negedge reset) begin
        if (!reset)
            issue_valid <= 1'b0;
        else
            issue_valid <= (sel == sel_direct) || (sel == sel_held);
    end

    always_ff @(posedge clk) begin
        case (sel)
            sel_held: begin
                issue_op <= held_op;
                issue_pc <= held_pc;
                issue_rd <= held_rd;
                issue_a  <= a_value;
                issue_b  <= b_value;
            end
            sel_direct: begin
                issue_op <= dispatch_op;
                issue_pc <= dispatch_pc;
                issue_rd <= dispatch_rd;
                issue_a  <= new_a_value;
                issue_b  <= new_b_value;
            end
            // Nothing issues, payload holds
            default: begin
            end
        endcase
    end

endmodule

/* hdl/rs_entry.sv */
`timescale 1ns/1ps

// The single held instruction with its operand tracking
module rs_entry
    import rs_params_pkg::*, rs_types_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  capture,
    input  logic                  release_entry,
    input  alu_op_t               dispatch_op,
    input  logic [pc_width-1:0]   dispatch_pc,
    input  logic [preg_width-1:0] dispatch_rd,
    input  tag_t                  a_tag,
    input  logic [data_width-1:0] a_data,
    input  tag_t                  b_tag,
    input  logic [data_width-1:0] b_data,
    input  logic                  cdb_valid_0,
    input  logic [data_width-1:0] cdb_data_0,
    input  logic                  cdb_valid_1,
    input  logic [data_width-1:0] cdb_data_1,
    input  logic                  cdb_valid_2,
    input  logic [data_width-1:0] cdb_data_2,
    input  logic                  cdb_valid_load,
    input  logic [preg_width-1:0] cdb_dest_load,
    input  logic [data_width-1:0] cdb_data_load,
    output logic                  occupied,
    output alu_op_t               held_op,
    output logic [pc_width-1:0]   held_pc,
    output logic [preg_width-1:0] held_rd,
    output logic                  a_resolved,
    output logic [data_width-1:0] a_value,
    output logic                  b_resolved,
    output logic [data_width-1:0] b_value,
    output logic                  new_a_resolved,
    output logic [data_width-1:0] new_a_value,
    output logic                  new_b_resolved,
    output logic [data_width-1:0] new_b_value
);

    logic [num_alu_channels-1:0] cdb_valid;
    tag_t                        a_tag_q;
    tag_t                        b_tag_q;
    logic [data_width-1:0]       a_data_q;
    logic [data_width-1:0]       b_data_q;

    assign cdb_valid = {cdb_valid_2, cdb_valid_1, cdb_valid_0};

    // ====================
    // Operand snooping
    // ====================

    // Held operands
    operand_snoop snoop_held_a (
        .held_tag(a_tag_q), .held_data(a_data_q), .cdb_valid(cdb_valid),
        .cdb_data_0(cdb_data_0), .cdb_data_1(cdb_data_1), .cdb_data_2(cdb_data_2),
        .cdb_valid_load(cdb_valid_load), .cdb_dest_load(cdb_dest_load),
        .cdb_data_load(cdb_data_load), .resolved(a_resolved), .value(a_value)
    );

    operand_snoop snoop_held_b (
        .held_tag(b_tag_q), .held_data(b_data_q), .cdb_valid(cdb_valid),
        .cdb_data_0(cdb_data_0), .cdb_data_1(cdb_data_1), .cdb_data_2(cdb_data_2),
        .cdb_valid_load(cdb_valid_load), .cdb_dest_load(cdb_dest_load),
        .cdb_data_load(cdb_data_load), .resolved(b_resolved), .value(b_value)
    );

    // Incoming operands, so a same-cycle broadcast is not missed
    operand_snoop snoop_new_a (
        .held_tag(a_tag), .held_data(a_data), .cdb_valid(cdb_valid),
        .cdb_data_0(cdb_data_0), .cdb_data_1(cdb_data_1), .cdb_data_2(cdb_data_2),
        .cdb_valid_load(cdb_valid_load), .cdb_dest_load(cdb_dest_load),
        .cdb_data_load(cdb_data_load), .resolved(new_a_resolved), .value(new_a_value)
    );

    operand_snoop snoop_new_b (
        .held_tag(b_tag), .held_data(b_data), .cdb_valid(cdb_valid),
        .cdb_data_0(cdb_data_0), .cdb_data_1(cdb_data_1), .cdb_data_2(cdb_data_2),
        .cdb_valid_load(cdb_valid_load), .cdb_dest_load(cdb_dest_load),
        .cdb_data_load(cdb_data_load), .resolved(new_b_resolved), .value(new_b_value)
    );

    // ====================
    // Entry state
    // ====================

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            occupied <= 1'b0;
            a_tag_q  <= tag_ready;
            b_tag_q  <= tag_ready;
        end else begin
            if (capture) begin
                occupied <= 1'b1;
                a_tag_q  <= new_a_resolved ? tag_ready : a_tag;
                b_tag_q  <= new_b_resolved ? tag_ready : b_tag;
            end else if (release_entry) begin
                occupied <= 1'b0;
            end else if (occupied) begin
                // Mark each operand ready once its producer broadcasts
                if (a_resolved)
                    a_tag_q <= tag_ready;
                if (b_resolved)
                    b_tag_q <= tag_ready;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            held_op  <= dispatch_op;
            held_pc  <= dispatch_pc;
            held_rd  <= dispatch_rd;
            a_data_q <= new_a_resolved ? new_a_value : a_data;
            b_data_q <= new_b_resolved ? new_b_value : b_data;
        end else if (occupied) begin
            if (a_resolved)
                a_data_q <= a_value;
            if (b_resolved)
                b_data_q <= b_value;
        end
    end

endmodule

/* hdl/operand_snoop.sv */
`timescale 1ns/1ps

// Resolves one operand against the three ALU channels and the load channel
module operand_snoop
    import rs_params_pkg::*, rs_types_pkg::*;
(
    input  tag_t                        held_tag,
    input  logic [data_width-1:0]       held_data,
    input  logic [num_alu_channels-1:0] cdb_valid,
    input  logic [data_width-1:0]       cdb_data_0,
    input  logic [data_width-1:0]       cdb_data_1,
    input  logic [data_width-1:0]       cdb_data_2,
    input  logic                        cdb_valid_load,
    input  logic [preg_width-1:0]       cdb_dest_load,
    input  logic [data_width-1:0]       cdb_data_load,
    output logic                        resolved,
    output logic [data_width-1:0]       value
);

    logic load_match;

    // Loads are identified by their destination register
    assign load_match = cdb_valid_load && (held_data[preg_width-1:0] == cdb_dest_load);

    always_comb begin
        resolved = 1'b0;
        value    = held_data;
        case (held_tag)
            tag_ready: begin
                resolved = 1'b1;
            end
            tag_alu0: begin
                resolved = cdb_valid[0];
                if (cdb_valid[0])
                    value = cdb_data_0;
            end
            tag_alu1: begin
                resolved = cdb_valid[1];
                if (cdb_valid[1])
                    value = cdb_data_1;
            end
            tag_alu2: begin
                resolved = cdb_valid[2];
                if (cdb_valid[2])
                    value = cdb_data_2;
            end
            tag_load: begin
                resolved = load_match;
                if (load_match)
                    value = cdb_data_load;
            end
            // Unused encodings never resolve
            default: begin
                resolved = 1'b0;
            end
        endcase
    end

endmodule

/* hdl/rs_types_pkg.sv */
package rs_types_pkg;

    import rs_params_pkg::*;

    // Producer of an operand
    // For tag_load the operand data word holds the awaited physical register
    // in its low preg_width bits
    typedef enum logic [tag_width-1:0] {
        tag_alu0  = 3'b000,
        tag_alu1  = 3'b001,
        tag_alu2  = 3'b010,
        tag_load  = 3'b011,
        tag_ready = 3'b111
    } tag_t;

    // ALU operation, passed through to the functional unit untouched
    typedef enum logic [3:0] {
        op_add = 4'h0,
        op_sub = 4'h1,
        op_and = 4'h2,
        op_or  = 4'h3,
        op_xor = 4'h4,
        op_sll = 4'h5,
        op_srl = 4'h6,
        op_slt = 4'h7
    } alu_op_t;

endpackage

/* hdl/rs_params_pkg.sv */
package rs_params_pkg;

    // ====================
    // Datapath widths
    // ====================

    // Operand and result word
    localparam int data_width = 32;

    // Physical register file address
    localparam int preg_width = 6;

    // Program counter carried with each instruction
    localparam int pc_width = 32;

    // ====================
    // Dependency tracking
    // ====================

    // Encoded producer tag of an operand
    localparam int tag_width = 3;

    // ALU result channels on the CDB, one per ALU
    localparam int num_alu_channels = 3;

    // The load channel is matched on destination register, so only its
    // register field is needed next to the data word

endpackage
